//--- ipdc.f
logic/ipdc_pkg.sv
logic/image_buffer.sv
logic/op_control.sv
logic/window_scan.sv
logic/output_filter.sv
logic/ipdc_top.sv
dv/ipdc_assertions.sv
dv/ipdc_checker.sv
dv/ipdc_tb.sv

//--- Bender.yml
package:
  name: ipdc

sources:
  - logic/ipdc_pkg.sv
  - logic/image_buffer.sv
  - logic/op_control.sv
  - logic/window_scan.sv
  - logic/output_filter.sv
  - logic/ipdc_top.sv
  - target: test
    files:
      - dv/ipdc_assertions.sv
      - dv/ipdc_checker.sv
      - dv/ipdc_tb.sv

//--- dv/ipdc_testdata.txt
# opcode (hex)  expected output count (decimal)  test name
# display gives depth*4 outputs, convolution gives 4, all others none
0 0   load_image
7 128 display_origin_0
8 4   conv_origin_0
2 0   shift_left_at_border
3 0   shift_up_at_border
7 128 display_still_origin_0
1 0   shift_right_col_1
4 0   shift_down_row_1
7 128 display_origin_9
8 4   conv_origin_9
1 0   shift_right_col_2
1 0   shift_right_col_3
1 0   shift_right_col_4
1 0   shift_right_col_5
1 0   shift_right_col_6
1 0   shift_right_past_6
4 0   shift_down_row_2
4 0   shift_down_row_3
4 0   shift_down_row_4
4 0   shift_down_row_5
4 0   shift_down_row_6
4 0   shift_down_past_6
7 128 display_origin_54
8 4   conv_origin_54
5 0   depth_down_16
7 64  display_depth_16
5 0   depth_down_8
5 0   depth_down_saturate
7 32  display_depth_8
8 4   conv_depth_8
6 0   depth_up_16
6 0   depth_up_32
6 0   depth_up_saturate
7 128 display_depth_32
9 0   illegal_opcode_9
a 0   illegal_opcode_10
7 128 display_after_illegal

//--- dv/ipdc_tb.sv
`timescale 1ns/1ps

module ipdc_tb;

localparam int TIMEOUT = 5000;    // cycles allowed per wait
localparam int N_PIX   = 1 << ipdc_pkg::ADDR_W;

logic                         clk;
logic                         rst_n;
logic                         op_valid;
ipdc_pkg::op_mode_e           op_mode;
logic                         op_ready;
logic                         in_valid;
logic [ipdc_pkg::PIX_W-1:0]   in_data;
logic                         in_ready;
logic                         out_valid;
logic [ipdc_pkg::OUT_W-1:0]   out_data;
logic [31:0]                  lfsr_state;
logic                         run_ok;

ipdc_top dut0 (
	.i_clk       (clk),
	.i_rst_n     (rst_n),
	.i_op_valid  (op_valid),
	.i_op_mode   (op_mode),
	.o_op_ready  (op_ready),
	.i_in_valid  (in_valid),
	.i_in_data   (in_data),
	.o_in_ready  (in_ready),
	.o_out_valid (out_valid),
	.o_out_data  (out_data)
);

ipdc_checker u_checker (
	.i_clk       (clk),
	.i_rst_n     (rst_n),
	.i_op_valid  (op_valid),
	.i_op_mode   (op_mode),
	.i_op_ready  (op_ready),
	.i_in_valid  (in_valid),
	.i_in_data   (in_data),
	.i_in_ready  (in_ready),
	.i_out_valid (out_valid),
	.i_out_data  (out_data)
);

always #2 clk = !clk;

// galois lfsr stepped once per bit taken
function automatic logic lfsr_bit();
	logic lsb;
	lsb        = lfsr_state[0];
	lfsr_state = lfsr_state >> 1;
	if (lsb)
		lfsr_state = lfsr_state ^ 32'h8020_0003;
	return lsb;
endfunction

function automatic logic [7:0] next_pixel();
	logic [7:0] px;
	int         b;
	px = '0;
	for (b = 0; b < 8; b++)
		px = {px[6:0], lfsr_bit()};
	return px;
endfunction

// --------------------------------------------------
// host side
// --------------------------------------------------
task automatic wait_op_ready(output logic ok);
	int n;
	ok = 1'b0;
	n  = 0;
	while (!ok && n < TIMEOUT) begin
		@(negedge clk);
		ok = op_ready;
		n++;
	end
	if (!ok)
		$display("timeout: no o_op_ready pulse within %0d cycles", TIMEOUT);
endtask

task automatic stream_pixels(output logic ok);
	int sent, n, m;
	sent = 0;
	n    = 0;
	m    = 0;
	while (sent < N_PIX && n < TIMEOUT) begin
		in_valid = in_ready;
		if (in_ready) begin
			in_data = next_pixel();
			sent++;
		end
		@(negedge clk);
		n++;
	end
	// valid held high so a late o_in_ready fall takes an extra pixel
	while (in_ready && m < TIMEOUT) begin
		@(negedge clk);
		m++;
	end
	in_valid = 1'b0;
	ok = (sent == N_PIX) && !in_ready;
	if (!ok)
		$display("timeout: load sent %0d of %0d pixels or o_in_ready stayed high", sent, N_PIX);
endtask

task automatic run_op(input logic [3:0] op, input int count, input string name,
                      output logic ok);
	wait_op_ready(ok);
	if (ok) begin
		u_checker.expect_op(name, count);
		op_valid = 1'b1;
		op_mode  = ipdc_pkg::op_mode_e'(op);
		@(negedge clk);
		op_valid = 1'b0;
		if (op == ipdc_pkg::OP_LOAD)
			stream_pixels(ok);
	end
endtask

initial begin
	string      line;
	string      name;
	logic [3:0] op;
	int         count;
	int         fd;
	clk        = 1'b0;
	rst_n      = 1'b0;
	op_valid   = 1'b0;
	op_mode    = ipdc_pkg::OP_LOAD;
	in_valid   = 1'b0;
	in_data    = '0;
	lfsr_state = 32'h0c6d_f06e;
	run_ok     = 1'b1;
	repeat (10) @(posedge clk);
	@(negedge clk);
	rst_n = 1'b1;

	fd = $fopen("dv/ipdc_testdata.txt", "r");
	if (fd == 0) begin
		$display("could not open the test data file dv/ipdc_testdata.txt");
		run_ok = 1'b0;
	end
	while (run_ok && $fgets(line, fd) > 0) begin
		if (line.len() > 1 && line[0] != "#") begin
			if ($sscanf(line, "%h %d %s", op, count, name) == 3) begin
				run_op(op, count, name, run_ok);
			end else begin
				$display("malformed test data line: %s", line);
				run_ok = 1'b0;
			end
		end
	end
	if (fd != 0)
		$fclose(fd);
	if (run_ok)
		wait_op_ready(run_ok);    // ends the last operation
	@(negedge clk);    // checker samples on the edge before this
	u_checker.report();
	if (run_ok && u_checker.error_count == 0 && dut0.u_assertions.fail_count == 0)
		$display("Simulation finished: PASS");
	else
		$display("Simulation finished: FAIL");
	$finish;
end

endmodule

//--- dv/ipdc_checker.sv
`timescale 1ns/1ps

module ipdc_checker (
	input logic                          i_clk,
	input logic                          i_rst_n,
	input logic                          i_op_valid,
	input logic [3:0]                    i_op_mode,
	input logic                          i_op_ready,
	input logic                          i_in_valid,
	input logic [ipdc_pkg::PIX_W-1:0]    i_in_data,
	input logic                          i_in_ready,
	input logic                          i_out_valid,
	input logic [ipdc_pkg::OUT_W-1:0]    i_out_data
);

localparam int N_PIX   = 1 << ipdc_pkg::ADDR_W;
localparam int MAX_POS = 6;    // last row or column that keeps the window inside

logic [7:0] image [N_PIX];
int         exp_q [$];
int         row0, col0, depth;
int         load_cnt, out_cnt, exp_cnt;
int         tests = 0;
int         passed = 0;
int         error_count = 0;
int         test_errors = 0;
int         pending_cnt = 0;
string      name = "none";
string      pending_name = "none";
logic [3:0] cur_op;
logic       seen_ready, waiting, busy;

// set by the testbench as it issues an operation
task automatic expect_op(input string op_name, input int count);
	pending_name = op_name;
	pending_cnt  = count;
endtask

task automatic value_error(input string sig, input int exp, input int got);
	$display("error: %s expected 0x%h got 0x%h in %s", sig, exp, got, name);
	error_count++;
	test_errors++;
endtask

task automatic plain_error(input string msg);
	$display("%s", msg);
	error_count++;
	test_errors++;
endtask

// --------------------------------------------------
// reference values
// --------------------------------------------------
function automatic int conv_value(input int pos);
	int sum, ch, kr, kc, r, c;
	sum = 0;
	for (ch = 0; ch < depth; ch++)
		for (kr = 0; kr < 3; kr++)
			for (kc = 0; kc < 3; kc++) begin
				r = row0 + pos / 2 + kr - 1;
				c = col0 + pos % 2 + kc - 1;
				if (r >= 0 && r < 8 && c >= 0 && c < 8)    // zero padding
					sum += int'(image[ch * 64 + r * 8 + c])
					       * (kr == 1 ? 2 : 1) * (kc == 1 ? 2 : 1);
			end
	return (sum + 8) / 16;
endfunction

task automatic start_op(input logic [3:0] op);
	int ch, p;
	case (op)
		ipdc_pkg::OP_LOAD:     load_cnt = 0;
		ipdc_pkg::OP_SHIFT_R:  if (col0 < MAX_POS) col0++;
		ipdc_pkg::OP_SHIFT_L:  if (col0 > 0) col0--;
		ipdc_pkg::OP_SHIFT_U:  if (row0 > 0) row0--;
		ipdc_pkg::OP_SHIFT_D:  if (row0 < MAX_POS) row0++;
		ipdc_pkg::OP_DEPTH_DN: depth = (depth == 32) ? 16 : 8;
		ipdc_pkg::OP_DEPTH_UP: depth = (depth == 8) ? 16 : 32;
		ipdc_pkg::OP_DISPLAY:
			for (ch = 0; ch < depth; ch++)
				for (p = 0; p < 4; p++)
					exp_q.push_back(int'(image[ch * 64 + (row0 + p / 2) * 8 + col0 + p % 2]));
		ipdc_pkg::OP_CONV:
			for (p = 0; p < 4; p++)
				exp_q.push_back(conv_value(p));
		default: ;    // illegal opcode has no effect
	endcase
endtask

task automatic close_test();
	if (exp_q.size() > 0)
		plain_error($sformatf("%s ended with %0d outputs missing", name, exp_q.size()));
	if (out_cnt != exp_cnt)
		value_error("o_out_valid count", exp_cnt, out_cnt);
	if (cur_op == ipdc_pkg::OP_LOAD && load_cnt != N_PIX)
		value_error("accepted pixel count", N_PIX, load_cnt);
	tests++;
	if (test_errors == 0)
		passed++;
	$display("%-26s %s, %0d outputs", name, (test_errors == 0) ? "ok" : "bad", out_cnt);
	exp_q.delete();
	busy = 1'b0;
endtask

task automatic report();
	$display("%0d tests, %0d passed, %0d failed, %0d errors",
	         tests, passed, tests - passed, error_count);
endtask

// --------------------------------------------------
// samples what the DUT saw at each edge
// --------------------------------------------------
always @(posedge i_clk) begin
	int exp;
	if (!i_rst_n) begin
		row0       = 0;
		col0       = 0;
		depth      = ipdc_pkg::MAX_DEPTH;
		load_cnt   = 0;
		seen_ready = 1'b0;
		waiting    = 1'b0;
		busy       = 1'b0;
		exp_q.delete();
	end else begin
		if (!seen_ready && (i_out_valid || i_in_ready))
			plain_error("o_out_valid or o_in_ready high before the first o_op_ready pulse");
		if (i_in_valid && i_in_ready) begin
			if (load_cnt < N_PIX)
				image[load_cnt] = i_in_data;
			load_cnt++;
		end
		if (i_out_valid) begin
			out_cnt++;
			if (exp_q.size() == 0) begin
				plain_error($sformatf("o_out_valid with no output expected in %s", name));
			end else begin
				exp = exp_q.pop_front();
				if (i_out_data !== ipdc_pkg::OUT_W'(exp))
					value_error("o_out_data", exp, int'(i_out_data));
			end
		end
		if (i_op_ready) begin
			if (busy)
				close_test();
			seen_ready = 1'b1;
			waiting    = 1'b1;
		end
		if (i_op_valid && waiting) begin
			waiting     = 1'b0;
			busy        = 1'b1;
			name        = pending_name;
			exp_cnt     = pending_cnt;
			out_cnt     = 0;
			test_errors = 0;
			cur_op      = i_op_mode;
			start_op(i_op_mode);
		end
	end
end

endmodule

//--- dv/ipdc_assertions.sv
`timescale 1ns/1ps

module ipdc_assertions (
	input logic               i_clk,
	input logic               i_rst_n,
	input logic               i_op_valid,
	input ipdc_pkg::op_mode_e i_op_mode,
	input logic               i_op_ready,
	input logic               i_in_ready,
	input logic               i_out_valid
);

int fail_count = 0;

// ready is a single cycle pulse
ready_pulse: assert property (@(posedge i_clk) disable iff (!i_rst_n)
	i_op_ready |=> !i_op_ready)
	else begin
		$error("o_op_ready high on two consecutive cycles");
		fail_count++;
	end

no_out_with_ready: assert property (@(posedge i_clk) disable iff (!i_rst_n)
	!(i_out_valid && i_op_ready))
	else begin
		$error("o_out_valid high together with o_op_ready");
		fail_count++;
	end

// in_ready only opens right after a load op
in_ready_after_load: assert property (@(posedge i_clk) disable iff (!i_rst_n)
	$rose(i_in_ready) |-> $past(i_op_valid && i_op_mode == ipdc_pkg::OP_LOAD))
	else begin
		$error("o_in_ready rose without a load operation");
		fail_count++;
	end

in_ready_quiet: assert property (@(posedge i_clk) disable iff (!i_rst_n)
	i_in_ready |-> !i_op_ready && !i_out_valid)
	else begin
		$error("o_in_ready high during ready pulse or output");
		fail_count++;
	end

endmodule

bind ipdc_top ipdc_assertions u_assertions (
	.i_clk       (i_clk),
	.i_rst_n     (i_rst_n),
	.i_op_valid  (i_op_valid),
	.i_op_mode   (i_op_mode),
	.i_op_ready  (o_op_ready),
	.i_in_ready  (o_in_ready),
	.i_out_valid (o_out_valid)
);

//--- logic/ipdc_top.sv
`timescale 1ns/1ps

module ipdc_top (
	input  logic                            i_clk,
	input  logic                            i_rst_n,
	input  logic                            i_op_valid,
	input  ipdc_pkg::op_mode_e              i_op_mode,
	output logic                            o_op_ready,
	input  logic                            i_in_valid,
	input  logic [ipdc_pkg::PIX_W-1:0]      i_in_data,
	output logic                            o_in_ready,
	output logic                            o_out_valid,
	output logic [ipdc_pkg::OUT_W-1:0]      o_out_data
);

// --------------------------------------------------
// internal connections
// --------------------------------------------------
logic                            wr_en;
logic [ipdc_pkg::ADDR_W-1:0]     wr_addr;
logic [ipdc_pkg::PIX_W-1:0]      wr_data;
logic                            rd_en;
logic [ipdc_pkg::ADDR_W-1:0]     rd_addr;
logic [ipdc_pkg::PIX_W-1:0]      rd_data;
logic                            scan_start;
logic                            conv_mode;
logic [ipdc_pkg::ORIGIN_W-1:0]   origin;
ipdc_pkg::depth_e                depth;
logic                            tap_valid;
logic                            tap_pad;
logic [1:0]                      tap_pos;
logic [1:0]                      tap_weight_sel;
logic                            tap_last;
logic                            done;

op_control u_op_control (
	.i_clk        (i_clk),
	.i_rst_n      (i_rst_n),
	.i_op_valid   (i_op_valid),
	.i_op_mode    (i_op_mode),
	.i_in_valid   (i_in_valid),
	.i_in_data    (i_in_data),
	.i_done       (done),
	.o_op_ready   (o_op_ready),
	.o_in_ready   (o_in_ready),
	.o_wr_en      (wr_en),
	.o_wr_addr    (wr_addr),
	.o_wr_data    (wr_data),
	.o_scan_start (scan_start),
	.o_conv_mode  (conv_mode),
	.o_origin     (origin),
	.o_depth      (depth)
);

image_buffer #(.ADDR_W(ipdc_pkg::ADDR_W), .DATA_W(ipdc_pkg::PIX_W)) u_image_buffer (
	.i_clk     (i_clk),
	.i_wr_en   (wr_en),
	.i_wr_addr (wr_addr),
	.i_wr_data (wr_data),
	.i_rd_en   (rd_en),
	.i_rd_addr (rd_addr),
	.o_rd_data (rd_data)
);

window_scan u_window_scan (
	.i_clk (i_clk), .i_rst_n (i_rst_n),
	.i_scan_start (scan_start), .i_conv_mode (conv_mode),
	.i_origin (origin), .i_depth (depth),
	.o_rd_en (rd_en), .o_rd_addr (rd_addr),
	.o_tap_valid (tap_valid), .o_tap_pad (tap_pad), .o_tap_pos (tap_pos),
	.o_tap_weight_sel (tap_weight_sel), .o_tap_last (tap_last)
);

output_filter u_output_filter (
	.i_clk (i_clk), .i_rst_n (i_rst_n), .i_conv_mode (conv_mode), .i_rd_data (rd_data),
	.i_tap_valid (tap_valid), .i_tap_pad (tap_pad), .i_tap_pos (tap_pos),
	.i_tap_weight_sel (tap_weight_sel), .i_tap_last (tap_last),
	.o_out_valid (o_out_valid), .o_out_data (o_out_data), .o_done (done)
);

endmodule

//--- logic/output_filter.sv
`timescale 1ns/1ps

module output_filter (
	input  logic                            i_clk,
	input  logic                            i_rst_n,
	input  logic                            i_conv_mode,
	input  logic [ipdc_pkg::PIX_W-1:0]      i_rd_data,
	input  logic                            i_tap_valid,
	input  logic                            i_tap_pad,
	input  logic [1:0]                      i_tap_pos,
	input  logic [1:0]                      i_tap_weight_sel,
	input  logic                            i_tap_last,
	output logic                            o_out_valid,
	output logic [ipdc_pkg::OUT_W-1:0]      o_out_data,
	output logic                            o_done
);

// kernel weights sum to 16 per channel
localparam int ACC_W = ipdc_pkg::PIX_W + 4 + $clog2(ipdc_pkg::MAX_DEPTH);

logic [ACC_W-1:0] acc [ipdc_pkg::D_AREA];
logic [ACC_W-1:0] term;
logic [ACC_W-1:0] rounded;
logic             emit_busy;
logic [1:0]       emit_idx;
logic             disp_tap;

assign disp_tap = i_tap_valid && !i_conv_mode;
assign term     = i_tap_pad ? '0 : ACC_W'(i_rd_data) << i_tap_weight_sel;    // x1 x2 x4
assign rounded  = acc[emit_idx] + ACC_W'(8);

// --------------------------------------------------
// Gaussian accumulators
// --------------------------------------------------
always_ff @(posedge i_clk) begin
	if (i_tap_valid && i_conv_mode)
		acc[i_tap_pos] <= acc[i_tap_pos] + term;
	else if (!emit_busy)
		for (int i = 0; i < ipdc_pkg::D_AREA; i++)
			acc[i] <= '0;    // cleared between scans
end

always_ff @(posedge i_clk or negedge i_rst_n) begin
	if (!i_rst_n) begin
		emit_busy   <= 1'b0;
		emit_idx    <= '0;
		o_out_valid <= 1'b0;
		o_done      <= 1'b0;
	end else begin
		o_out_valid <= disp_tap || emit_busy;
		o_done      <= disp_tap && i_tap_last;
		if (i_tap_valid && i_conv_mode && i_tap_last) begin
			emit_busy <= 1'b1;
			emit_idx  <= '0;
		end else if (emit_busy) begin
			emit_idx <= emit_idx + 1'b1;
			if (emit_idx == ipdc_pkg::D_AREA - 1) begin
				emit_busy <= 1'b0;
				o_done    <= 1'b1;    // with the fourth result
			end
		end
	end
end

always_ff @(posedge i_clk) begin
	if (emit_busy)
		o_out_data <= ipdc_pkg::OUT_W'(rounded >> 4);
	else
		o_out_data <= ipdc_pkg::OUT_W'(i_rd_data);    // display pixel
end

endmodule

//--- logic/window_scan.sv
`timescale 1ns/1ps

module window_scan (
	input  logic                            i_clk,
	input  logic                            i_rst_n,
	input  logic                            i_scan_start,
	input  logic                            i_conv_mode,
	input  logic [ipdc_pkg::ORIGIN_W-1:0]   i_origin,
	input  ipdc_pkg::depth_e                i_depth,
	output logic                            o_rd_en,
	output logic [ipdc_pkg::ADDR_W-1:0]     o_rd_addr,
	output logic                            o_tap_valid,
	output logic                            o_tap_pad,
	output logic [1:0]                      o_tap_pos,
	output logic [1:0]                      o_tap_weight_sel,
	output logic                            o_tap_last
);

localparam int CH_W = $clog2(ipdc_pkg::MAX_DEPTH);
localparam int XY_W = $clog2(ipdc_pkg::C_WIDTH);

logic            busy;
logic [CH_W-1:0] ch;
logic [1:0]      pos;                 // bit 0 column, bit 1 row
logic [1:0]      kr, kc;
logic [1:0]      off_r, off_c;
logic [XY_W+1:0] row, col;            // wide enough for -1 and 8
logic            pad, tap_end, pos_end, ch_end, last;
logic [1:0]      wsel;
logic            s1_pad, s1_last;
logic [1:0]      s1_pos, s1_wsel;

// --------------------------------------------------
// tap position and border check
// --------------------------------------------------
always_comb begin
	off_r   = i_conv_mode ? kr : 2'd1;    // display reads the center only
	off_c   = i_conv_mode ? kc : 2'd1;
	row     = (XY_W+2)'(i_origin[ipdc_pkg::ORIGIN_W-1:XY_W]) + (XY_W+2)'(pos[1])
	          + (XY_W+2)'(off_r) - 1'b1;
	col     = (XY_W+2)'(i_origin[XY_W-1:0]) + (XY_W+2)'(pos[0])
	          + (XY_W+2)'(off_c) - 1'b1;
	pad     = (row >= ipdc_pkg::C_LENGTH) || (col >= ipdc_pkg::C_WIDTH);
	wsel    = 2'(off_r == 2'd1) + 2'(off_c == 2'd1);    // corner 0 edge 1 center 2
	tap_end = !i_conv_mode
	          || (kr == ipdc_pkg::K_WIDTH - 1 && kc == ipdc_pkg::K_WIDTH - 1);
	pos_end = (pos == ipdc_pkg::D_AREA - 1);
	ch_end  = (int'(ch) == int'(i_depth) - 1);
	last    = tap_end && pos_end && ch_end;
end

// channel, position, tap counters
always_ff @(posedge i_clk or negedge i_rst_n) begin
	if (!i_rst_n) begin
		busy <= 1'b0;
		ch   <= '0;
		pos  <= '0;
		kr   <= '0;
		kc   <= '0;
	end else if (i_scan_start) begin
		busy <= 1'b1;
		ch   <= '0;
		pos  <= '0;
		kr   <= '0;
		kc   <= '0;
	end else if (busy) begin
		if (last)
			busy <= 1'b0;
		if (!tap_end) begin
			if (kc == ipdc_pkg::K_WIDTH - 1) begin
				kc <= '0;
				kr <= kr + 1'b1;
			end else begin
				kc <= kc + 1'b1;
			end
		end else begin
			kr  <= '0;
			kc  <= '0;
			pos <= pos + 1'b1;    // wraps after bottom-right
			if (pos_end)
				ch <= ch + 1'b1;
		end
	end
end

// --------------------------------------------------
// read issue and tag delay
// --------------------------------------------------
always_ff @(posedge i_clk or negedge i_rst_n) begin
	if (!i_rst_n) begin
		o_rd_en     <= 1'b0;
		o_tap_valid <= 1'b0;
	end else begin
		o_rd_en     <= busy;
		o_tap_valid <= o_rd_en;    // buffer data valid now
	end
end

always_ff @(posedge i_clk) begin
	o_rd_addr        <= {ch, row[XY_W-1:0], col[XY_W-1:0]};
	s1_pad           <= pad;
	s1_pos           <= pos;
	s1_wsel          <= wsel;
	s1_last          <= last;
	o_tap_pad        <= s1_pad;
	o_tap_pos        <= s1_pos;
	o_tap_weight_sel <= s1_wsel;
	o_tap_last       <= s1_last;
end

endmodule

//--- logic/op_control.sv
`timescale 1ns/1ps

module op_control (
	input  logic                            i_clk,
	input  logic                            i_rst_n,
	input  logic                            i_op_valid,
	input  ipdc_pkg::op_mode_e              i_op_mode,
	input  logic                            i_in_valid,
	input  logic [ipdc_pkg::PIX_W-1:0]      i_in_data,
	input  logic                            i_done,
	output logic                            o_op_ready,
	output logic                            o_in_ready,
	output logic                            o_wr_en,
	output logic [ipdc_pkg::ADDR_W-1:0]     o_wr_addr,
	output logic [ipdc_pkg::PIX_W-1:0]      o_wr_data,
	output logic                            o_scan_start,
	output logic                            o_conv_mode,
	output logic [ipdc_pkg::ORIGIN_W-1:0]   o_origin,
	output ipdc_pkg::depth_e                o_depth
);

localparam int XY_W    = $clog2(ipdc_pkg::C_WIDTH);
localparam int MAX_COL = ipdc_pkg::C_WIDTH - ipdc_pkg::D_WIDTH;     // window stays inside
localparam int MAX_ROW = ipdc_pkg::C_LENGTH - ipdc_pkg::D_WIDTH;

ipdc_pkg::ctrl_state_e            state;
ipdc_pkg::op_mode_e               op_mode_r;
logic [ipdc_pkg::ADDR_W-1:0]      wr_cnt;
logic [XY_W-1:0]                  col;
logic [XY_W-1:0]                  row;
logic                             accept;

assign col          = o_origin[XY_W-1:0];
assign row          = o_origin[ipdc_pkg::ORIGIN_W-1:XY_W];
assign accept       = o_in_ready && i_in_valid;
assign o_in_ready   = (state == ipdc_pkg::ST_LOAD);
assign o_scan_start = (state == ipdc_pkg::ST_SCAN);      // one cycle after the op
assign o_conv_mode  = (op_mode_r == ipdc_pkg::OP_CONV);

// --------------------------------------------------
// sequencer
// --------------------------------------------------
always_ff @(posedge i_clk or negedge i_rst_n) begin
	if (!i_rst_n) begin
		state      <= ipdc_pkg::ST_IDLE;
		op_mode_r  <= ipdc_pkg::OP_LOAD;
		o_op_ready <= 1'b0;
		wr_cnt     <= '0;
		o_origin   <= '0;
		o_depth    <= ipdc_pkg::DEPTH_32;
	end else begin
		o_op_ready <= (state == ipdc_pkg::ST_READY);    // single cycle pulse
		case (state)
			ipdc_pkg::ST_IDLE:  state <= ipdc_pkg::ST_READY;
			ipdc_pkg::ST_READY: state <= ipdc_pkg::ST_WAIT_OP;
			ipdc_pkg::ST_WAIT_OP: begin
				if (i_op_valid) begin
					op_mode_r <= i_op_mode;
					state     <= ipdc_pkg::ST_IDLE;
					case (i_op_mode)
						ipdc_pkg::OP_LOAD: begin
							state  <= ipdc_pkg::ST_LOAD;
							wr_cnt <= '0;
						end
						ipdc_pkg::OP_SHIFT_R: if (col < MAX_COL) o_origin <= o_origin + 1'b1;
						ipdc_pkg::OP_SHIFT_L: if (col > 0) o_origin <= o_origin - 1'b1;
						ipdc_pkg::OP_SHIFT_U:
							if (row > 0) o_origin <= o_origin - ipdc_pkg::ORIGIN_W'(ipdc_pkg::C_WIDTH);
						ipdc_pkg::OP_SHIFT_D:
							if (row < MAX_ROW) o_origin <= o_origin + ipdc_pkg::ORIGIN_W'(ipdc_pkg::C_WIDTH);
						ipdc_pkg::OP_DEPTH_DN:
							o_depth <= (o_depth == ipdc_pkg::DEPTH_32) ? ipdc_pkg::DEPTH_16
							                                           : ipdc_pkg::DEPTH_8;
						ipdc_pkg::OP_DEPTH_UP:
							o_depth <= (o_depth == ipdc_pkg::DEPTH_8) ? ipdc_pkg::DEPTH_16
							                                          : ipdc_pkg::DEPTH_32;
						ipdc_pkg::OP_DISPLAY, ipdc_pkg::OP_CONV: state <= ipdc_pkg::ST_SCAN;
						default: state <= ipdc_pkg::ST_IDLE;    // illegal opcode
					endcase
				end
			end
			ipdc_pkg::ST_LOAD: begin
				if (accept) begin
					wr_cnt <= wr_cnt + 1'b1;
					if (&wr_cnt)
						state <= ipdc_pkg::ST_IDLE;    // 2048th pixel
				end
			end
			ipdc_pkg::ST_SCAN:  state <= ipdc_pkg::ST_DRAIN;
			ipdc_pkg::ST_DRAIN: if (i_done) state <= ipdc_pkg::ST_IDLE;
			default:            state <= ipdc_pkg::ST_IDLE;
		endcase
	end
end

// load writes land one cycle after acceptance
always_ff @(posedge i_clk or negedge i_rst_n) begin
	if (!i_rst_n)
		o_wr_en <= 1'b0;
	else
		o_wr_en <= accept;
end

always_ff @(posedge i_clk) begin
	o_wr_addr <= wr_cnt;
	o_wr_data <= i_in_data;
end

endmodule

//--- logic/image_buffer.sv
`timescale 1ns/1ps

module image_buffer #(
	parameter int ADDR_W = 11,
	parameter int DATA_W = 8
) (
	input  logic              i_clk,
	input  logic              i_wr_en,
	input  logic [ADDR_W-1:0] i_wr_addr,
	input  logic [DATA_W-1:0] i_wr_data,
	input  logic              i_rd_en,
	input  logic [ADDR_W-1:0] i_rd_addr,
	output logic [DATA_W-1:0] o_rd_data
);

localparam int WORDS = 1 << ADDR_W;

logic [DATA_W-1:0] mem [WORDS];

always_ff @(posedge i_clk) begin
	if (i_wr_en)
		mem[i_wr_addr] <= i_wr_data;
	if (i_rd_en)
		o_rd_data <= mem[i_rd_addr];    // one cycle latency, holds otherwise
end

endmodule

//--- logic/ipdc_pkg.sv
package ipdc_pkg;

// --------------------------------------------------
// channel, window and kernel sizes
// --------------------------------------------------
localparam int C_WIDTH   = 8;
localparam int C_LENGTH  = 8;
localparam int MAX_DEPTH = 32;
localparam int D_WIDTH   = 2;
localparam int D_AREA    = D_WIDTH * D_WIDTH;
localparam int K_WIDTH   = 3;
localparam int K_AREA    = K_WIDTH * K_WIDTH;

localparam int PIX_W     = 8;
localparam int ADDR_W    = 11;    // 32 channels of 64 pixels
localparam int OUT_W     = 14;
localparam int ORIGIN_W  = 6;     // row * 8 + col

// --------------------------------------------------
// encodings
// --------------------------------------------------
typedef enum logic [3:0] {
	OP_LOAD     = 4'd0,
	OP_SHIFT_R  = 4'd1,
	OP_SHIFT_L  = 4'd2,
	OP_SHIFT_U  = 4'd3,
	OP_SHIFT_D  = 4'd4,
	OP_DEPTH_DN = 4'd5,
	OP_DEPTH_UP = 4'd6,
	OP_DISPLAY  = 4'd7,
	OP_CONV     = 4'd8
} op_mode_e;

// value is the channel count
typedef enum logic [5:0] {DEPTH_8 = 6'd8, DEPTH_16 = 6'd16, DEPTH_32 = 6'd32} depth_e;

typedef enum logic [2:0] {ST_IDLE, ST_READY, ST_WAIT_OP, ST_LOAD, ST_SCAN, ST_DRAIN} ctrl_state_e;

endpackage
